/* verilog.f */
design/memcheck_pkg.sv
design/obi_xfer_fifo.sv
design/rvfi_retire_tracker.sv
design/rvfi_memop_rebuild.sv
design/rvfi_mem_compare.sv
design/rvfi_mem_checker.sv
tests/rvfi_mem_checker_tb.sv

/* Bender.yml */
package:
  name: rvfi_mem_checker

sources:
  - files:
      - design/memcheck_pkg.sv
      - design/obi_xfer_fifo.sv
      - design/rvfi_retire_tracker.sv
      - design/rvfi_memop_rebuild.sv
      - design/rvfi_mem_compare.sv
      - design/rvfi_mem_checker.sv
  - target: test
    files:
      - tests/rvfi_mem_checker_tb.sv

/* tests/rvfi_mem_checker_tb.sv */
`timescale 1ns/1ps

module rvfi_mem_checker_tb;

  localparam int unsigned CLK_HALF_NS = 2;
  localparam int unsigned NUM_INSTR = 128;
  // Worst case per instruction is four transfers with three stall cycles each
  localparam int unsigned TIMEOUT_NS = (NUM_INSTR * 40 + 20) * 2 * CLK_HALF_NS;

  typedef enum logic [2:0] {
    corrupt_none, corrupt_addr, corrupt_mask, corrupt_rdata, corrupt_wdata, corrupt_err
  } corrupt_t;

  // One instruction of the stimulus model, in RVFI terms
  typedef struct packed {
    logic              two_ops;
    logic              is_read;
    logic [2:0]        size;
    logic [1:0]        lsb;
    logic [1:0][31:0]  addr;
    logic [1:0][31:0]  data;
    logic [3:0]        xfer_err;
    corrupt_t          corrupt;
    logic              cslot;
    logic [1:0]        cbyte;
  } instr_t;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        obi_req_valid_i;
  logic                        obi_gnt_i;
  memcheck_pkg::obi_req_t      obi_req_i;
  logic                        obi_rvalid_i;
  memcheck_pkg::obi_resp_t     obi_resp_i;
  logic                        rvfi_valid_i;
  memcheck_pkg::rvfi_mem_t     rvfi_mem_i;
  memcheck_pkg::check_result_t result_o;

  logic [31:0]                 lfsr_q = 32'h37497ec0;
  memcheck_pkg::check_result_t exp_q[$];
  string                       name_q[$];
  int unsigned                 n_checks = 0;
  int unsigned                 n_value_err = 0;
  int unsigned                 n_other_err = 0;

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  rvfi_mem_checker dut_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .obi_req_valid_i (obi_req_valid_i),
    .obi_gnt_i       (obi_gnt_i),
    .obi_req_i       (obi_req_i),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_resp_i      (obi_resp_i),
    .rvfi_valid_i    (rvfi_valid_i),
    .rvfi_mem_i      (rvfi_mem_i),
    .result_o        (result_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [3:0] size_mask(logic [2:0] size);
    return (size == 3'd4) ? 4'b1111 : (size == 3'd2) ? 4'b0011 : 4'b0001;
  endfunction

  // RVFI data is right aligned and bytes above the access size are zero
  function automatic logic [31:0] op_data(instr_t ins, int k);
    logic [31:0] keep;
    keep = (ins.size == 3'd4) ? 32'hffff_ffff : (ins.size == 3'd2) ? 32'h0000_ffff : 32'h0000_00ff;
    return ins.data[k] & keep;
  endfunction

  function automatic logic is_split(instr_t ins);
    return (int'(ins.lsb) + int'(ins.size)) > 4;
  endfunction

  // Bus lanes that are not enabled carry junk
  function automatic logic [31:0] fill_lanes(logic [31:0] data, logic [3:0] be,
                                             logic [31:0] junk);
    logic [31:0] out;
    for (int b = 0; b < 4; b++) begin
      out[8*b +: 8] = be[b] ? data[8*b +: 8] : junk[8*b +: 8];
    end
    return out;
  endfunction

  // Flags follow from the corruption alone; data flags need an enabled byte
  function automatic memcheck_pkg::check_result_t expected_result(instr_t ins);
    memcheck_pkg::check_result_t res;
    logic                        byte_on;
    res = '0;
    res.valid = 1'b1;
    byte_on = {1'b0, ins.cbyte} < ins.size;
    case (ins.corrupt)
      corrupt_addr:  res.memop[ins.cslot].addr_err = 1'b1;
      corrupt_mask:  res.memop[ins.cslot].mask_err = 1'b1;
      corrupt_rdata: res.memop[ins.cslot].rdata_err = ins.is_read && byte_on;
      corrupt_wdata: res.memop[ins.cslot].wdata_err = !ins.is_read && byte_on;
      corrupt_err:   res.memop[ins.cslot].err_err = 1'b1;
      default: ;
    endcase
    return res;
  endfunction

  function automatic instr_t random_instr(corrupt_t kind, logic aligned, int dir_mode);
    instr_t     ins;
    logic [1:0] sel;
    int         idx;
    ins = '0;
    ins.two_ops = aligned ? 1'b0 : 1'(take_bits(1));
    ins.is_read = (dir_mode == 1) ? 1'b1 : (dir_mode == 2) ? 1'b0 : 1'(take_bits(1));
    sel = 2'(take_bits(2));
    if (aligned) begin
      ins.size = 3'd4;
    end else if (kind == corrupt_mask) begin
      // A shifted mask keeps its popcount only below a full word
      ins.size = sel[0] ? 3'd2 : 3'd1;
    end else begin
      ins.size = (sel == 2'd0) ? 3'd1 : (sel == 2'd1) ? 3'd2 : 3'd4;
    end
    ins.lsb = aligned ? 2'b00 : 2'(take_bits(2));
    for (int k = 0; k < 2; k++) begin
      ins.addr[k] = {30'(take_bits(30)), ins.lsb};
      ins.data[k] = take_bits(32);
    end
    ins.xfer_err = 4'(take_bits(4)) & 4'(take_bits(4));
    ins.corrupt = kind;
    ins.cslot = ins.two_ops ? 1'(take_bits(1)) : 1'b0;
    ins.cbyte = 2'(take_bits(2));
    if (kind == corrupt_err) begin
      idx = is_split(ins) ? 2 * int'(ins.cslot) + int'(take_bits(1)) : int'(ins.cslot);
      ins.xfer_err[idx] = 1'b1;
    end
    return ins;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_xfer(memcheck_pkg::obi_req_t req, memcheck_pkg::obi_resp_t resp);
    int unsigned stall;
    stall = take_bits(2);
    obi_req_valid_i = 1'b1;
    obi_req_i = req;
    obi_gnt_i = 1'b0;
    repeat (stall) next_cycle();
    obi_gnt_i = 1'b1;
    next_cycle();
    obi_req_valid_i = 1'b0;
    // A grant without a request must not be stored
    obi_gnt_i = 1'(take_bits(1));
    obi_rvalid_i = 1'b1;
    obi_resp_i = resp;
    next_cycle();
    obi_rvalid_i = 1'b0;
    obi_gnt_i = 1'b0;
  endtask

  task automatic issue_instr(instr_t ins);
    logic [7:0]              be_span;
    logic [63:0]             d_span;
    memcheck_pkg::obi_req_t  req;
    memcheck_pkg::obi_resp_t resp;
    int                      x;
    x = 0;
    for (int k = 0; k < (ins.two_ops ? 2 : 1); k++) begin
      be_span = {4'b0000, size_mask(ins.size)} << ins.lsb;
      d_span = {32'h0, op_data(ins, k)} << (8 * ins.lsb);
      req.addr = ins.addr[k];
      req.be = be_span[3:0];
      req.we = !ins.is_read;
      req.wdata = fill_lanes(d_span[31:0], be_span[3:0], take_bits(32));
      resp.rdata = fill_lanes(d_span[31:0], be_span[3:0], take_bits(32));
      resp.err = ins.xfer_err[x];
      send_xfer(req, resp);
      x++;
      if (is_split(ins)) begin
        // The upper half goes to the next word
        req.addr = {ins.addr[k][31:2], 2'b00} + 32'd4;
        req.be = be_span[7:4];
        req.wdata = fill_lanes(d_span[63:32], be_span[7:4], take_bits(32));
        resp.rdata = fill_lanes(d_span[63:32], be_span[7:4], take_bits(32));
        resp.err = ins.xfer_err[x];
        send_xfer(req, resp);
        x++;
      end
    end
  endtask

  task automatic report_instr(instr_t ins, string name);
    memcheck_pkg::rvfi_mem_t mem;
    logic [3:0]              m;
    mem = '0;
    m = size_mask(ins.size);
    for (int k = 0; k < (ins.two_ops ? 2 : 1); k++) begin
      mem[k].addr = ins.addr[k];
      mem[k].rmask = ins.is_read ? m : 4'b0000;
      mem[k].wmask = ins.is_read ? 4'b0000 : m;
      mem[k].rdata = ins.is_read ? op_data(ins, k) : 32'h0;
      mem[k].wdata = ins.is_read ? 32'h0 : op_data(ins, k);
      mem[k].err = is_split(ins) ? (ins.xfer_err[2*k] | ins.xfer_err[2*k+1]) : ins.xfer_err[k];
      if (int'(ins.cslot) == k) begin
        case (ins.corrupt)
          corrupt_addr:  mem[k].addr[20] = ~mem[k].addr[20];
          corrupt_mask:  begin
            mem[k].rmask = mem[k].rmask << 1;
            mem[k].wmask = mem[k].wmask << 1;
          end
          corrupt_rdata: mem[k].rdata = mem[k].rdata ^ (32'h1 << (8 * ins.cbyte));
          corrupt_wdata: mem[k].wdata = mem[k].wdata ^ (32'h1 << (8 * ins.cbyte));
          corrupt_err:   mem[k].err = 1'b0;
          default: ;
        endcase
      end
    end
    rvfi_mem_i = mem;
    rvfi_valid_i = 1'b1;
    exp_q.push_back(expected_result(ins));
    name_q.push_back(name);
    next_cycle();
    rvfi_valid_i = 1'b0;
  endtask

  task automatic run_test(string name, int count, corrupt_t kind, logic aligned, int dir_mode);
    instr_t ins;
    for (int i = 0; i < count; i++) begin
      ins = random_instr(kind, aligned, dir_mode);
      issue_instr(ins);
      report_instr(ins, name);
    end
  endtask

  // Two instructions are on the bus before the first one retires
  task automatic run_back_to_back(string name, int pairs);
    instr_t first;
    instr_t second;
    for (int i = 0; i < pairs; i++) begin
      first = random_instr(corrupt_none, 1'b0, 0);
      second = random_instr(corrupt_none, 1'b0, 0);
      issue_instr(first);
      issue_instr(second);
      report_instr(first, name);
      report_instr(second, name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  // A report seen at an edge must show up in the next low phase, else the result stays clear
  initial begin : compare_results
    logic                        was_valid;
    memcheck_pkg::check_result_t cur_exp;
    string                       cur_name;
    forever begin
      @(posedge clk_i);
      was_valid = rvfi_valid_i;
      cur_exp = '0;
      cur_name = "idle";
      if (was_valid && exp_q.size() == 0) begin
        n_other_err++;
        $display("a report reached the DUT with no expected result queued");
      end else if (was_valid) begin
        cur_exp = exp_q.pop_front();
        cur_name = name_q.pop_front();
      end
      @(negedge clk_i);
      n_checks++;
      if (result_o !== cur_exp) begin
        n_value_err++;
        $display("error %s expected %h actual %h", cur_name, cur_exp, result_o);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("run timed out before all instructions were checked");
    $display("TB FAILED");
    $finish;
  end

  initial begin : main_seq
    rst_ni = 1'b0;
    obi_req_valid_i = 1'b0;
    obi_gnt_i = 1'b0;
    obi_req_i = '0;
    obi_rvalid_i = 1'b0;
    obi_resp_i = '0;
    rvfi_valid_i = 1'b0;
    rvfi_mem_i = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (result_o !== '0) begin
      n_value_err++;
      $display("error reset expected %h actual %h", 11'h0, result_o);
    end
    next_cycle();
    run_test("aligned_word", 8, corrupt_none, 1'b1, 0);
    run_test("sub_word", 40, corrupt_none, 1'b0, 0);
    run_test("addr_corrupt", 10, corrupt_addr, 1'b0, 0);
    run_test("mask_corrupt", 10, corrupt_mask, 1'b0, 0);
    run_test("rdata_corrupt", 12, corrupt_rdata, 1'b0, 1);
    run_test("wdata_corrupt", 12, corrupt_wdata, 1'b0, 2);
    run_test("err_missing", 10, corrupt_err, 1'b0, 0);
    run_test("err_reported", 10, corrupt_none, 1'b0, 0);
    run_back_to_back("back_to_back", 8);
    repeat (3) next_cycle();
    if (exp_q.size() != 0) begin
      n_other_err++;
      $display("%0d reports never produced a result", exp_q.size());
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_value_err, n_other_err);
    if (n_value_err + n_other_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* design/rvfi_mem_checker.sv */
`timescale 1ns/1ps

module rvfi_mem_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        obi_req_valid_i,
  input  logic                        obi_gnt_i,
  input  memcheck_pkg::obi_req_t      obi_req_i,
  input  logic                        obi_rvalid_i,
  input  memcheck_pkg::obi_resp_t     obi_resp_i,
  input  logic                        rvfi_valid_i,
  input  memcheck_pkg::rvfi_mem_t     rvfi_mem_i,
  output memcheck_pkg::check_result_t result_o
);

  logic                                                  req_push;
  logic                                                  split;
  memcheck_pkg::xfer_ptr_t [memcheck_pkg::MAX_XFER-1:0] xfer_idx;
  memcheck_pkg::obi_req_t  [memcheck_pkg::MAX_XFER-1:0] req_rd;
  memcheck_pkg::obi_resp_t [memcheck_pkg::MAX_XFER-1:0] resp_rd;
  memcheck_pkg::rvfi_mem_t                               exp_mem;

  ////////////////////////////////////////////////////////////
  // Transfer capture
  ////////////////////////////////////////////////////////////

  // Only the address phase that the bus accepted is stored
  assign req_push = obi_req_valid_i & obi_gnt_i;

  obi_xfer_fifo #(
    .payload_t (memcheck_pkg::obi_req_t)
  ) i_req_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (req_push),
    .push_data_i (obi_req_i),
    .rd_idx_i    (xfer_idx),
    .rd_data_o   (req_rd)
  );

  obi_xfer_fifo #(
    .payload_t (memcheck_pkg::obi_resp_t)
  ) i_resp_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (obi_rvalid_i),
    .push_data_i (obi_resp_i),
    .rd_idx_i    (xfer_idx),
    .rd_data_o   (resp_rd)
  );

  // Both FIFOs advance in lockstep, since every OBI request gets exactly one
  // response, so a single read pointer serves them
  rvfi_retire_tracker i_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_mem_i   (rvfi_mem_i),
    .xfer_idx_o   (xfer_idx),
    .split_o      (split)
  );

  ////////////////////////////////////////////////////////////
  // Expected report and compare
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < memcheck_pkg::MAX_MEMOP; k++) begin : g_memop
    rvfi_memop_rebuild i_rebuild (
      .is_read_i     (|rvfi_mem_i[k].rmask),
      .split_i       (split),
      .req_first_i   (req_rd[2*k]),
      .req_second_i  (req_rd[2*k+1]),
      .resp_first_i  (resp_rd[2*k]),
      .resp_second_i (resp_rd[2*k+1]),
      .exp_o         (exp_mem[k])
    );
  end

  rvfi_mem_compare i_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi_valid_i (rvfi_valid_i),
    .rvfi_mem_i   (rvfi_mem_i),
    .exp_i        (exp_mem),
    .result_o     (result_o)
  );

endmodule

/* design/rvfi_mem_compare.sv */
`timescale 1ns/1ps

module rvfi_mem_compare (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rvfi_valid_i,
  input  memcheck_pkg::rvfi_mem_t     rvfi_mem_i,
  input  memcheck_pkg::rvfi_mem_t     exp_i,
  output memcheck_pkg::check_result_t result_o
);

  memcheck_pkg::memop_mismatch_t [memcheck_pkg::MAX_MEMOP-1:0] mismatch;
  memcheck_pkg::check_result_t                                 result_q;

  ////////////////////////////////////////////////////////////
  // Per-slot field compare
  ////////////////////////////////////////////////////////////

  always_comb begin : slot_compare
    logic                            active;
    logic [memcheck_pkg::DATA_W-1:0] rd_bits;
    logic [memcheck_pkg::DATA_W-1:0] wr_bits;
    for (int k = 0; k < memcheck_pkg::MAX_MEMOP; k++) begin
      active  = (|rvfi_mem_i[k].rmask) || (|rvfi_mem_i[k].wmask);
      // Data lanes are judged by what the bus actually transferred
      rd_bits = memcheck_pkg::be_to_bitmask(exp_i[k].rmask);
      wr_bits = memcheck_pkg::be_to_bitmask(exp_i[k].wmask);

      mismatch[k].addr_err  = active && (exp_i[k].addr != rvfi_mem_i[k].addr);
      mismatch[k].mask_err  = active && ((exp_i[k].rmask != rvfi_mem_i[k].rmask) ||
                                         (exp_i[k].wmask != rvfi_mem_i[k].wmask));
      mismatch[k].rdata_err = active &&
                              (|((exp_i[k].rdata ^ rvfi_mem_i[k].rdata) & rd_bits));
      mismatch[k].wdata_err = active &&
                              (|((exp_i[k].wdata ^ rvfi_mem_i[k].wdata) & wr_bits));
      mismatch[k].err_err   = active && (exp_i[k].err != rvfi_mem_i[k].err);
    end
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Flags are only kept for cycles that carried a report
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else begin
      result_q.valid <= rvfi_valid_i;
      result_q.memop <= rvfi_valid_i ? mismatch : '0;
    end
  end

  assign result_o = result_q;

endmodule

/* design/rvfi_memop_rebuild.sv */
`timescale 1ns/1ps

module rvfi_memop_rebuild (
  input  logic                      is_read_i,
  input  logic                      split_i,
  input  memcheck_pkg::obi_req_t    req_first_i,
  input  memcheck_pkg::obi_req_t    req_second_i,
  input  memcheck_pkg::obi_resp_t   resp_first_i,
  input  memcheck_pkg::obi_resp_t   resp_second_i,
  output memcheck_pkg::rvfi_memop_t exp_o
);

  logic [memcheck_pkg::OFFS_W-1:0] lsb;
  logic [memcheck_pkg::OFFS_W:0]   second_shift;
  logic [memcheck_pkg::DATA_W-1:0] first_bits;
  logic [memcheck_pkg::DATA_W-1:0] second_bits;
  logic [memcheck_pkg::DATA_W-1:0] first_wdata;
  logic [memcheck_pkg::DATA_W-1:0] second_wdata;
  logic [memcheck_pkg::DATA_W-1:0] first_rdata;
  logic [memcheck_pkg::DATA_W-1:0] second_rdata;
  logic [memcheck_pkg::BE_W-1:0]   mask;
  logic [memcheck_pkg::DATA_W-1:0] wdata;
  logic [memcheck_pkg::DATA_W-1:0] rdata;
  logic                            err;

  // Byte offset of the operation inside the first word
  assign lsb = req_first_i.addr[memcheck_pkg::OFFS_W-1:0];

  // The second half of a split operation starts right after the bytes that
  // the first word could hold
  assign second_shift = {1'b1, {memcheck_pkg::OFFS_W{1'b0}}} - {1'b0, lsb};

  ////////////////////////////////////////////////////////////
  // Lane masking of both halves
  ////////////////////////////////////////////////////////////

  assign first_bits  = memcheck_pkg::be_to_bitmask(req_first_i.be);
  assign second_bits = memcheck_pkg::be_to_bitmask(req_second_i.be);

  // Disabled lanes may carry anything on the bus, so clear them before merging
  assign first_wdata  = req_first_i.wdata & first_bits;
  assign second_wdata = req_second_i.wdata & second_bits;
  assign first_rdata  = resp_first_i.rdata & first_bits;
  assign second_rdata = resp_second_i.rdata & second_bits;

  ////////////////////////////////////////////////////////////
  // Alignment to the RVFI view
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (split_i) begin
      mask  = (req_first_i.be >> lsb) | (req_second_i.be << second_shift);
      wdata = (first_wdata >> {lsb, 3'b000}) |
              (second_wdata << {second_shift, 3'b000});
      rdata = (first_rdata >> {lsb, 3'b000}) |
              (second_rdata << {second_shift, 3'b000});
      // A fault on either half fails the whole operation
      err   = resp_first_i.err | resp_second_i.err;
    end else begin
      mask  = req_first_i.be >> lsb;
      wdata = req_first_i.wdata >> {lsb, 3'b000};
      rdata = resp_first_i.rdata >> {lsb, 3'b000};
      err   = resp_first_i.err;
    end
  end

  // RVFI reports the byte address of the operation, which is the address of
  // the first transfer in both cases
  always_comb begin
    exp_o.addr  = req_first_i.addr;
    exp_o.rmask = is_read_i ? mask : '0;
    exp_o.wmask = is_read_i ? '0 : mask;
    exp_o.rdata = rdata;
    exp_o.wdata = wdata;
    exp_o.err   = err;
  end

endmodule

/* design/rvfi_retire_tracker.sv */
`timescale 1ns/1ps

module rvfi_retire_tracker (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  rvfi_valid_i,
  input  memcheck_pkg::rvfi_mem_t                               rvfi_mem_i,
  output memcheck_pkg::xfer_ptr_t [memcheck_pkg::MAX_XFER-1:0] xfer_idx_o,
  output logic                                                  split_o
);

  memcheck_pkg::xfer_ptr_t           rd_ptr_q;
  memcheck_pkg::xfer_ptr_t           num_memop;
  memcheck_pkg::xfer_ptr_t           num_xfer;
  logic [memcheck_pkg::BE_W-1:0]     slot0_mask;
  logic [memcheck_pkg::OFFS_W+1:0]   slot0_span;

  ////////////////////////////////////////////////////////////
  // Operation count and split detection
  ////////////////////////////////////////////////////////////

  // Slots fill from 0 upward, so counting active slots is enough
  always_comb begin
    num_memop = '0;
    for (int k = 0; k < memcheck_pkg::MAX_MEMOP; k++) begin
      if ((|rvfi_mem_i[k].rmask) || (|rvfi_mem_i[k].wmask)) begin
        num_memop = num_memop + 1'b1;
      end
    end
  end

  assign slot0_mask = rvfi_mem_i[0].rmask | rvfi_mem_i[0].wmask;

  // Start offset plus byte count past the word boundary means two transfers
  always_comb begin
    slot0_span = {2'b00, rvfi_mem_i[0].addr[memcheck_pkg::OFFS_W-1:0]};
    for (int b = 0; b < memcheck_pkg::BE_W; b++) begin
      slot0_span = slot0_span + slot0_mask[b];
    end
  end

  // Every operation of one instruction shares the alignment of slot 0
  assign split_o = slot0_span > memcheck_pkg::BE_W;

  ////////////////////////////////////////////////////////////
  // Transfer indices and read pointer
  ////////////////////////////////////////////////////////////

  // Index 2k is the first transfer of operation k and index 2k+1 its second
  // half, which the rebuilder ignores unless the operation is split
  always_comb begin
    for (int k = 0; k < memcheck_pkg::MAX_MEMOP; k++) begin
      if (split_o) begin
        xfer_idx_o[2*k]   = rd_ptr_q + memcheck_pkg::xfer_ptr_t'(2*k);
        xfer_idx_o[2*k+1] = rd_ptr_q + memcheck_pkg::xfer_ptr_t'(2*k + 1);
      end else begin
        xfer_idx_o[2*k]   = rd_ptr_q + memcheck_pkg::xfer_ptr_t'(k);
        xfer_idx_o[2*k+1] = rd_ptr_q + memcheck_pkg::xfer_ptr_t'(k + 1);
      end
    end
  end

  assign num_xfer = split_o ? num_memop + num_memop : num_memop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
    end else if (rvfi_valid_i) begin
      rd_ptr_q <= rd_ptr_q + num_xfer;
    end
  end

endmodule

/* design/obi_xfer_fifo.sv */
`timescale 1ns/1ps

module obi_xfer_fifo #(
  parameter type payload_t = memcheck_pkg::obi_req_t
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            push_i,
  input  payload_t                                        push_data_i,
  input  memcheck_pkg::xfer_ptr_t [memcheck_pkg::MAX_XFER-1:0] rd_idx_i,
  output payload_t [memcheck_pkg::MAX_XFER-1:0]           rd_data_o
);

  payload_t                mem_q [memcheck_pkg::FIFO_DEPTH];
  memcheck_pkg::xfer_ptr_t wr_ptr_q;

  // Write pointer wraps at FIFO_DEPTH because the depth equals 2**PTR_W
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (push_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Each read port returns the entry at its own index, without any handshake.
  // Old entries are simply overwritten once the pointer comes around again
  always_comb begin
    for (int i = 0; i < memcheck_pkg::MAX_XFER; i++) begin
      rd_data_o[i] = mem_q[rd_idx_i[i]];
    end
  end

endmodule

/* design/memcheck_pkg.sv */
package memcheck_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W = 4;

  // Byte offset inside a word
  localparam int unsigned OFFS_W = $clog2(BE_W);

  // The depth is a power of two so that both pointers wrap on their own
  localparam int unsigned PTR_W = 3;
  localparam int unsigned FIFO_DEPTH = 1 << PTR_W;

  localparam int unsigned MAX_MEMOP = 2;

  // A misaligned operation takes two OBI transfers
  localparam int unsigned MAX_XFER = 2 * MAX_MEMOP;

  typedef logic [PTR_W-1:0] xfer_ptr_t;

  ////////////////////////////////////////////////////////////
  // OBI data-side payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_resp_t;

  ////////////////////////////////////////////////////////////
  // RVFI memory report and check results
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [BE_W-1:0]   rmask;
    logic [BE_W-1:0]   wmask;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic              err;
  } rvfi_memop_t;

  typedef rvfi_memop_t [MAX_MEMOP-1:0] rvfi_mem_t;

  typedef struct packed {
    logic addr_err;
    logic mask_err;
    logic rdata_err;
    logic wdata_err;
    logic err_err;
  } memop_mismatch_t;

  typedef struct packed {
    logic                             valid;
    memop_mismatch_t [MAX_MEMOP-1:0] memop;
  } check_result_t;

  // Expands byte enables into a mask covering every bit of each enabled byte
  function automatic logic [DATA_W-1:0] be_to_bitmask(logic [BE_W-1:0] be);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < BE_W; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

endpackage
